//--- filelist.f
logic/quad_pkg.sv
logic/board_pkg.sv
logic/reset_timer.sv
logic/enc_filter.sv
logic/quad_fsm.sv
logic/position_counter.sv
logic/quad_enc.sv
logic/enc_board_top.sv
verif/tb_enc_board.sv

//--- Bender.yml
package:
  name: enc_board

sources:
  - files:
      - logic/quad_pkg.sv
      - logic/board_pkg.sv
      - logic/reset_timer.sv
      - logic/enc_filter.sv
      - logic/quad_fsm.sv
      - logic/position_counter.sv
      - logic/quad_enc.sv
      - logic/enc_board_top.sv
  - target: simulation
    files:
      - verif/tb_enc_board.sv

//--- verif/tb_enc_board.sv
// self-checking testbench for the two-axis encoder board that drives ideal quadrature phases
module tb_enc_board;

  import quad_pkg::*;
  import board_pkg::*;

  localparam int pipe_len     = 2 + filter_len + 2; // pin edge to led and faultn in cycles
  localparam int phase_hold   = 8;   // each phase level is held longer than the filter needs
  localparam int reset_cycles = 16;  // board reset length
  localparam int wait_limit   = 64;  // no wait loop spends more cycles than this

  logic                 clk;
  logic                 resetn;
  logic                 enc1a;
  logic                 enc1b;
  logic                 enc2a;
  logic                 enc2b;
  logic [led_width-1:0] led;
  logic                 faultn;

  // encoder model with one entry per axis
  int unsigned phase_idx [axis_count]; // place in the gray sequence 00 01 11 10
  logic [3:0]  ref_count [axis_count]; // count modulo 16 as the leds should show it
  logic        ref_fault [axis_count]; // sticky once an illegal jump was made

  // model outputs delayed by the fixed dut latency
  logic [led_width-1:0] led_pipe    [pipe_len+1];
  logic                 faultn_pipe [pipe_len+1];

  logic        hold_check; // tracking checks rest while a reset moves through the dut
  logic        rst_window; // leds must read zero and faultn high
  int          value_errors;
  int          timeout_errors;
  int unsigned seed_val;

  enc_board_top dut (
    .clk    (clk),
    .resetn (resetn),
    .enc1a  (enc1a),
    .enc1b  (enc1b),
    .enc2a  (enc2a),
    .enc2b  (enc2b),
    .led    (led),
    .faultn (faultn)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // led pattern the model stands for right now, axis 1 in the low nibble
  function automatic logic [led_width-1:0] model_led();
    return {ref_count[1], ref_count[0]};
  endfunction

  // quadrature sequence taken as a then b
  function automatic logic [1:0] gray_phase(input int unsigned idx);
    case (idx % 4)
      0:       return 2'b00;
      1:       return 2'b01;
      2:       return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  // the delay line is fed at every edge so it lines up with the dut pipeline
  always @(posedge clk) begin
    led_pipe[0]    <= model_led();
    faultn_pipe[0] <= !(ref_fault[0] || ref_fault[1]);
    for (int i = 1; i <= pipe_len; i++) begin
      led_pipe[i]    <= led_pipe[i-1];
      faultn_pipe[i] <= faultn_pipe[i-1];
    end
  end

  led_tracks_model: assert property (@(posedge clk) disable iff (hold_check)
      led == led_pipe[pipe_len])
    else begin
      value_errors++;
      $display("Error at %0t: led is %h but the model expects %h", $time,
               $sampled(led), $sampled(led_pipe[pipe_len]));
    end

  fault_tracks_model: assert property (@(posedge clk) disable iff (hold_check)
      faultn == faultn_pipe[pipe_len])
    else begin
      value_errors++;
      $display("Error at %0t: faultn is %b but the model expects %b", $time,
               $sampled(faultn), $sampled(faultn_pipe[pipe_len]));
    end

  // in reset and during the hold after it nothing may count or fault
  reset_outputs_idle: assert property (@(posedge clk)
      !rst_window || (led == '0 && faultn == 1'b1))
    else begin
      value_errors++;
      $display("Error at %0t: led %h faultn %b inside the reset window", $time,
               $sampled(led), $sampled(faultn));
    end

  // inputs always change one time unit after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_pins(input int axis, input logic [1:0] ph);
    if (axis == 0) begin
      enc1a = ph[1];
      enc1b = ph[0];
    end else begin
      enc2a = ph[1];
      enc2b = ph[0];
    end
  endtask

  // random phase on both axes, opposite jumps included
  task automatic scramble_pins();
    for (int ax = 0; ax < axis_count; ax++) begin
      phase_idx[ax] = $urandom % 4;
      set_pins(ax, gray_phase(phase_idx[ax]));
    end
  endtask

  // one legal quadrature step, the count is frozen once the axis has faulted
  task automatic step_axis(input int axis, input bit up);
    phase_idx[axis] = up ? (phase_idx[axis] + 1) % 4 : (phase_idx[axis] + 3) % 4;
    if (!ref_fault[axis]) begin
      ref_count[axis] = up ? ref_count[axis] + 4'd1 : ref_count[axis] - 4'd1;
    end
    set_pins(axis, gray_phase(phase_idx[axis]));
    repeat (phase_hold) next_cycle();
  endtask

  // both phases flip in the same cycle
  task automatic illegal_jump(input int axis);
    phase_idx[axis] = (phase_idx[axis] + 2) % 4;
    ref_fault[axis] = 1'b1;
    set_pins(axis, gray_phase(phase_idx[axis]));
    repeat (phase_hold) next_cycle();
  endtask

  // a short pulse on one phase that the filter has to swallow
  task automatic glitch_phase(input int axis, input bit on_a, input int len);
    set_pins(axis, gray_phase(phase_idx[axis]) ^ (on_a ? 2'b10 : 2'b01));
    repeat (len) next_cycle();
    set_pins(axis, gray_phase(phase_idx[axis])); // back to the level the model holds
    repeat (phase_hold) next_cycle();
  endtask

  task automatic wait_led_match(input string what);
    int n;
    n = 0;
    while (led !== model_led() && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (led !== model_led()) begin
      timeout_errors++;
      $display("timeout: the leds never reached the model count after %s", what);
    end
  endtask

  task automatic wait_fault_low();
    int n;
    n = 0;
    while (faultn !== 1'b0 && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (faultn !== 1'b0) begin
      timeout_errors++;
      $display("timeout: faultn never went low after the illegal jump on axis 2");
    end
  endtask

  // board reset with the pins thrashing in reset and through most of the hold time
  task automatic apply_reset();
    hold_check = 1'b1;
    resetn     = 1'b0;
    for (int ax = 0; ax < axis_count; ax++) begin
      ref_count[ax] = '0;
      ref_fault[ax] = 1'b0;
    end
    repeat (3) next_cycle();
    rst_window = 1'b1; // the counters have been cleared by now
    for (int i = 0; i < 8; i++) begin
      scramble_pins();
      next_cycle();
    end
    repeat (reset_cycles - 3 - 8) next_cycle();
    resetn = 1'b1;
    // an early encoder release would count these moves or flag a fault
    for (int i = 0; i < reset_hold - 4; i++) begin
      scramble_pins();
      next_cycle();
    end
    repeat (4) next_cycle(); // pins settle before the encoder reset lets go
    rst_window = 1'b0;
    repeat (pipe_len + 2) next_cycle(); // let the delay line flush
    hold_check = 1'b0;
  endtask

  initial begin
    int ax;
    bit up;
    int len;
    resetn         = 1'b0;
    enc1a          = 1'b0;
    enc1b          = 1'b0;
    enc2a          = 1'b0;
    enc2b          = 1'b0;
    hold_check     = 1'b1;
    rst_window     = 1'b0;
    value_errors   = 0;
    timeout_errors = 0;
    for (int i = 0; i < axis_count; i++) begin
      phase_idx[i] = 0;
      ref_count[i] = '0;
      ref_fault[i] = 1'b0;
    end
    seed_val = $urandom(32'haa56eb1c);
    apply_reset();
    // long runs so the low nibble wraps up on axis 1 and down on axis 2
    repeat (18) step_axis(0, 1'b1);
    wait_led_match("the forward run on axis 1");
    repeat (18) step_axis(1, 1'b0);
    wait_led_match("the reverse run on axis 2");
    for (int burst = 0; burst < 10; burst++) begin
      ax  = $urandom % 2;
      up  = ($urandom % 2) != 0;
      len = 1 + $urandom % 12;
      repeat (len) step_axis(ax, up);
    end
    wait_led_match("the random bursts");
    for (int g = 0; g < 8; g++) begin
      glitch_phase($urandom % 2, ($urandom % 2) != 0, 1 + $urandom % (filter_len - 1));
    end
    illegal_jump(1);
    wait_fault_low();
    repeat (6) begin
      step_axis(1, ($urandom % 2) != 0); // axis 2 is frozen and must not move
      step_axis(0, ($urandom % 2) != 0);
    end
    wait_led_match("the steps after the axis 2 fault");
    apply_reset();
    wait_led_match("the recovery reset");
    repeat (5) step_axis(1, 1'b1);
    wait_led_match("the steps after recovery");
    $display("checks done with %0d value errors and %0d timeouts", value_errors,
             timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- logic/enc_board_top.sv
// board top for two encoder axes, shows each count's low nibble on the leds and one fault line
module enc_board_top (
  input  logic                           clk,
  input  logic                           resetn, // board reset, synchronous and active low
  input  logic                           enc1a,
  input  logic                           enc1b,
  input  logic                           enc2a,
  input  logic                           enc2b,
  output logic [board_pkg::led_width-1:0] led,   // axis 1 on led[3:0], axis 2 on led[7:4]
  output logic                           faultn  // low when either axis has faulted
);

  import board_pkg::*;
  import quad_pkg::*;

  logic                   enc_resetn;               // encoder reset after the hold time
  logic [count_width-1:0] count [axis_count];       // position per axis
  logic [axis_count-1:0]  axis_faultn;              // fault per axis, active low

  reset_timer u_reset_timer (
    .clk        (clk),
    .resetn     (resetn),
    .enc_resetn (enc_resetn)
  );

  quad_enc quad1 (
    .clk    (clk),
    .resetn (enc_resetn),
    .a      (enc1a),
    .b      (enc1b),
    .count  (count[0]),
    .faultn (axis_faultn[0])
  );

  quad_enc quad2 (
    .clk    (clk),
    .resetn (enc_resetn),
    .a      (enc2a),
    .b      (enc2b),
    .count  (count[1]),
    .faultn (axis_faultn[1])
  );

  // each axis gets its own nibble, count bit 3 lands on the nibble's top led
  always_comb begin
    for (int i = 0; i < axis_count; i++) begin
      led[i*led_bits_per_axis +: led_bits_per_axis] = count[i][led_bits_per_axis-1:0];
    end
  end

  assign faultn = &axis_faultn; // any faulted axis pulls the board line low

endmodule

//--- logic/quad_enc.sv
// one encoder axis that filters the pins, decodes the phase steps and keeps the position count
module quad_enc (
  input  logic                             clk,
  input  logic                             resetn, // stretched encoder reset
  input  logic                             a,      // raw phase a pin
  input  logic                             b,      // raw phase b pin
  output logic [quad_pkg::count_width-1:0] count,
  output logic                             faultn
);

  import quad_pkg::*;

  logic       a_filt;
  logic       b_filt;
  quad_step_t step;

  // pin to filtered level takes 2 + filter_len cycles
  enc_filter u_filter (
    .clk    (clk),
    .resetn (resetn),
    .a      (a),
    .b      (b),
    .a_filt (a_filt),
    .b_filt (b_filt)
  );

  // one more cycle to the step pulse
  quad_fsm u_fsm (
    .clk    (clk),
    .resetn (resetn),
    .a_filt (a_filt),
    .b_filt (b_filt),
    .step   (step)
  );

  // and one more to the count and fault
  position_counter u_counter (
    .clk    (clk),
    .resetn (resetn),
    .step   (step),
    .count  (count),
    .faultn (faultn)
  );

endmodule

//--- logic/position_counter.sv
// up/down position counter for one axis with a sticky fault that freezes the count
module position_counter (
  input  logic                               clk,
  input  logic                               resetn,
  input  quad_pkg::quad_step_t               step,
  output logic [quad_pkg::count_width-1:0]   count,  // two's complement, wraps
  output logic                               faultn  // low once an illegal move was seen
);

  import quad_pkg::*;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count  <= '0;
      faultn <= 1'b1;
    end else if (faultn) begin
      // steps only count while the axis is healthy
      case (step)
        step_up: begin
          count <= count + 1'b1; // wraps from 16'h7fff to 16'h8000 and 16'hffff to zero
        end
        step_down: begin
          count <= count - 1'b1;
        end
        step_illegal: begin
          faultn <= 1'b0; // count holds its last good value from here on
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  // once faultn is low nothing above touches the registers until the next reset

endmodule

//--- logic/quad_fsm.sv
// phase state machine that turns filtered a and b changes into up, down and illegal step pulses
module quad_fsm (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 a_filt,
  input  logic                 b_filt,
  output quad_pkg::quad_step_t step   // one-cycle pulse, step_none otherwise
);

  import quad_pkg::*;

  quad_phase_t phase_q;   // phase seen on the previous cycle
  quad_phase_t phase_in;  // phase on the filtered inputs now
  quad_phase_t phase_fwd; // phase one step forward from phase_q
  quad_phase_t phase_rev; // phase one step back from phase_q
  quad_step_t  step_d;    // classification of the move, registered into step

  assign phase_in = quad_phase_t'({a_filt, b_filt});

  // gray neighbours of the current phase in the order 00 01 11 10
  always_comb begin
    phase_fwd = ph_00;
    phase_rev = ph_00;
    case (phase_q)
      ph_00: begin
        phase_fwd = ph_01;
        phase_rev = ph_10;
      end
      ph_01: begin
        phase_fwd = ph_11;
        phase_rev = ph_00;
      end
      ph_11: begin
        phase_fwd = ph_10;
        phase_rev = ph_01;
      end
      ph_10: begin
        phase_fwd = ph_00;
        phase_rev = ph_11;
      end
      default: begin
        phase_fwd = ph_00;
        phase_rev = ph_00;
      end
    endcase
  end

  // the only phase that is neither equal nor a neighbour is the opposite one,
  // which means both phases flipped together
  always_comb begin
    if (phase_in == phase_q) begin
      step_d = step_none;
    end else if (phase_in == phase_fwd) begin
      step_d = step_up;
    end else if (phase_in == phase_rev) begin
      step_d = step_down;
    end else begin
      step_d = step_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_q <= phase_in;  // adopt the current phase so release emits no step
      step    <= step_none;
    end else begin
      phase_q <= phase_in;  // follow the inputs, illegal moves included
      step    <= step_d;    // pulse lands one cycle after the filtered change
    end
  end

endmodule

//--- logic/enc_filter.sv
// synchronizes one encoder's a and b pins and removes pulses too short to be real phase edges
module enc_filter (
  input  logic clk,
  input  logic resetn,
  input  logic a,      // asynchronous pin
  input  logic b,      // asynchronous pin
  output logic a_filt,
  output logic b_filt
);

  import quad_pkg::*;

  // index 1 carries phase a and index 0 carries phase b throughout
  logic [1:0] pin_meta; // first synchronizer stage, may go metastable
  logic [1:0] pin_sync; // second stage, safe to use in logic
  logic [1:0] pin_filt; // accepted level
  logic [filter_cnt_width-1:0] run_cnt [2]; // samples seen that disagree with pin_filt

  // plain two-flop synchronizer for both pins
  always_ff @(posedge clk) begin
    pin_meta <= {a, b};
    pin_sync <= pin_meta;
  end

  // one run counter per pin, a and b are filtered independently
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (!resetn) begin
        // take the pin level as it stands so no edge is seen at release
        pin_filt[i] <= pin_sync[i];
        run_cnt[i]  <= '0;
      end else if (pin_sync[i] == pin_filt[i]) begin
        run_cnt[i] <= '0; // pin agrees again, any pending change was a glitch
      end else if (run_cnt[i] == filter_cnt_width'(filter_len)) begin
        // filter_len disagreeing samples in a row and the pin still holds the new level
        pin_filt[i] <= pin_sync[i];
        run_cnt[i]  <= '0;
      end else begin
        run_cnt[i] <= run_cnt[i] + 1'b1;
      end
    end
  end

  // an edge sampled into pin_meta shows up here 2 + filter_len edges later
  assign a_filt = pin_filt[1];
  assign b_filt = pin_filt[0];

endmodule

//--- logic/reset_timer.sv
// stretches the board reset so the encoder logic leaves reset a fixed time after resetn rises
module reset_timer (
  input  logic clk,
  input  logic resetn,     // board reset, synchronous and active low
  output logic enc_resetn  // stretched reset for both encoder axes
);

  import board_pkg::*;

  // remaining hold cycles, reaches zero and then stays there
  logic [reset_cnt_width-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hold_cnt   <= reset_cnt_width'(reset_hold); // reload on every board reset
      enc_resetn <= 1'b0;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      // the release is taken from the count before this edge, so the first edge that
      // samples resetn high is cycle zero and enc_resetn rises on edge reset_hold
      enc_resetn <= (hold_cnt == '0);
    end
  end

endmodule

//--- logic/board_pkg.sv
// board level constants for the encoder board top and its reset timer
package board_pkg;

  // cycles that the encoder reset stays asserted after the board reset goes away
  localparam int reset_hold = 32;

  // down-counter width, it is loaded with reset_hold so it must hold that value
  localparam int reset_cnt_width = $clog2(reset_hold + 1);

  // two identical encoder axes on this board
  localparam int axis_count = 2;

  // low count bits shown on the leds for each axis
  localparam int led_bits_per_axis = 4;

  // total led bank, one nibble per axis
  localparam int led_width = axis_count * led_bits_per_axis;

endpackage

//--- logic/quad_pkg.sv
// quadrature decoding types and constants, imported by the filter, phase machine and counter
package quad_pkg;

  // gray-code phase of one encoder, bit 1 is phase a and bit 0 is phase b
  typedef enum logic [1:0] {
    ph_00 = 2'b00,
    ph_01 = 2'b01,
    ph_11 = 2'b11,
    ph_10 = 2'b10
  } quad_phase_t;

  // decoded event for one clock, step_none whenever the phase holds still
  typedef enum logic [1:0] {
    step_none    = 2'b00,
    step_up      = 2'b01, // forward gray neighbour 00 01 11 10
    step_down    = 2'b10, // reverse gray neighbour
    step_illegal = 2'b11  // both phases moved in the same cycle
  } quad_step_t;

  // consecutive synchronized samples that must disagree with the filtered level
  // before the filter commits the new level
  localparam int filter_len = 3;

  // the run counter has to be able to hold filter_len itself
  localparam int filter_cnt_width = $clog2(filter_len + 1);

  // signed position count, wraps modulo 2**count_width
  localparam int count_width = 16;

endpackage
